// ==== verilog/fp_defs_pkg.sv ====
/* Floating-point format definitions shared by the lanes and the result packer.
   Covers FP32/FP16 field widths, canonical NaNs and the status flag layout. */
package fp_defs_pkg;

  // Source format of an operation, destination is always the same
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  // ----------------------------------------
  // Format widths
  // ----------------------------------------
  localparam int unsigned FP32_W  = 32;
  localparam int unsigned EXP32_W = 8;
  localparam int unsigned MAN32_W = 23;

  localparam int unsigned FP16_W  = 16;
  localparam int unsigned EXP16_W = 5;
  localparam int unsigned MAN16_W = 10;

  localparam int unsigned SLICE_W = 32;

  // Operand and result words
  typedef logic [SLICE_W-1:0] slice_word_t;
  // One FP16 value, the unit of an upper lane
  typedef logic [FP16_W-1:0]  lane_word_t;

  // ----------------------------------------
  // Status flags {NV, DZ, OF, UF, NX}
  // ----------------------------------------
  typedef logic [4:0] status_t;

  localparam int unsigned NV_BIT = 4;

  // Canonical quiet NaNs, positive sign and only the quiet bit set
  localparam slice_word_t CANON_NAN32 = 32'h7fc0_0000;
  localparam lane_word_t  CANON_NAN16 = 16'h7e00;

endpackage

// ==== verilog/slice_ctrl_pkg.sv ====
/* Control definitions for the non-computational slice.
   Operation encoding, tag, lane count, pipeline depth and the aux bits that follow lane 0. */
package slice_ctrl_pkg;

  // Operations of the non-computational group
  typedef enum logic [2:0] {
    OP_MIN   = 3'd0,
    OP_MAX   = 3'd1,
    OP_SGNJ  = 3'd2,
    OP_SGNJN = 3'd3,
    OP_SGNJX = 3'd4
  } noncomp_op_e;

  // User tag, returned unchanged with the result
  typedef logic [3:0] tag_t;

  // ----------------------------------------
  // Slice structure
  // ----------------------------------------
  localparam int unsigned NUM_LANES     = 2;
  localparam int unsigned NUM_PIPE_REGS = 2;

  // Side information carried in lane 0's pipeline
  typedef logic [1:0] aux_t;

  // Bit positions inside aux_t
  localparam int unsigned AUX_VEC_BIT = 1;
  localparam int unsigned AUX_FMT_BIT = 0;

endpackage

// ==== verilog/lane_pipe.sv ====
`timescale 1ns/1ps
/* Valid/ready register pipeline for one lane, NUM_PIPE_REGS stages deep.
   A stage loads when the stage after it is ready or empty. Flush drops every item. */
module lane_pipe
  import slice_ctrl_pkg::*;
#(
  parameter int unsigned DATA_W = 32
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  logic [DATA_W-1:0] data_i,
  input  logic              flush_i,
  output logic [DATA_W-1:0] data_o,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output logic              busy_o
);

  // Stage registers, index NUM_PIPE_REGS-1 faces the output
  logic [NUM_PIPE_REGS-1:0]             valid_q;
  logic [NUM_PIPE_REGS-1:0][DATA_W-1:0] data_q;

  // What each stage sees on its upstream side
  logic [NUM_PIPE_REGS-1:0]             stage_in_valid;
  logic [NUM_PIPE_REGS-1:0][DATA_W-1:0] stage_in_data;
  logic [NUM_PIPE_REGS-1:0]             stage_ready;

  // ----------------------------------------
  // Stage linkage
  // ----------------------------------------
  for (genvar i = 0; i < NUM_PIPE_REGS; i++) begin : gen_link
    if (i == 0) begin : gen_head
      assign stage_in_valid[i] = in_valid_i;
      assign stage_in_data[i]  = data_i;
    end else begin : gen_body
      assign stage_in_valid[i] = valid_q[i-1];
      assign stage_in_data[i]  = data_q[i-1];
    end

    // Advance if downstream takes our item or we only hold a bubble
    if (i == NUM_PIPE_REGS - 1) begin : gen_tail
      assign stage_ready[i] = out_ready_i | ~valid_q[i];
    end else begin : gen_inner
      assign stage_ready[i] = stage_ready[i+1] | ~valid_q[i];
    end
  end

  // Valid bits, flush wins over a new item
  always_ff @(posedge clk_i) begin : valid_regs
    for (int i = 0; i < NUM_PIPE_REGS; i++) begin
      if (!rst_n_i || flush_i) begin
        valid_q[i] <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q[i] <= stage_in_valid[i];
      end
    end
  end

  // Payload only moves with a valid item
  always_ff @(posedge clk_i) begin : data_regs
    for (int i = 0; i < NUM_PIPE_REGS; i++) begin
      if (stage_ready[i] && stage_in_valid[i]) begin
        data_q[i] <= stage_in_data[i];
      end
    end
  end

  assign in_ready_o  = stage_ready[0];
  assign out_valid_o = valid_q[NUM_PIPE_REGS-1];
  assign data_o      = data_q[NUM_PIPE_REGS-1];
  assign busy_o      = |valid_q;

endmodule

// ==== verilog/noncomp_lane.sv ====
`timescale 1ns/1ps
/* Combinational min/max and sign-injection lane for one FP32 or FP16 value.
   The value sits in the low bits of the word; in FP16 the upper half is ignored. */
module noncomp_lane
  import fp_defs_pkg::*;
  import slice_ctrl_pkg::*;
(
  input  slice_word_t a_i,
  input  slice_word_t b_i,
  input  noncomp_op_e op_i,
  input  fp_fmt_e     fmt_i,
  output slice_word_t result_o,
  output status_t     status_o
);

  // Exponent and mantissa together, wide enough for FP32
  localparam int unsigned MAG_W = FP32_W - 1;

  logic             sign_a, sign_b;
  logic [MAG_W-1:0] mag_a, mag_b;
  logic             nan_a, nan_b;
  logic             snan_a, snan_b;
  logic             zero_a, zero_b;
  slice_word_t      canon_nan;
  logic             a_lt_b;
  logic             sign_inj;

  // ----------------------------------------
  // Operand classification
  // ----------------------------------------
  always_comb begin : classify
    if (fmt_i == FP32) begin
      sign_a    = a_i[FP32_W-1];
      sign_b    = b_i[FP32_W-1];
      mag_a     = a_i[MAG_W-1:0];
      mag_b     = b_i[MAG_W-1:0];
      nan_a     = (&a_i[MAG_W-1 -: EXP32_W]) && (|a_i[MAN32_W-1:0]);
      nan_b     = (&b_i[MAG_W-1 -: EXP32_W]) && (|b_i[MAN32_W-1:0]);
      // Quiet bit is the mantissa MSB
      snan_a    = nan_a && !a_i[MAN32_W-1];
      snan_b    = nan_b && !b_i[MAN32_W-1];
      canon_nan = CANON_NAN32;
    end else begin
      sign_a    = a_i[FP16_W-1];
      sign_b    = b_i[FP16_W-1];
      mag_a     = MAG_W'(a_i[FP16_W-2:0]);
      mag_b     = MAG_W'(b_i[FP16_W-2:0]);
      nan_a     = (&a_i[FP16_W-2 -: EXP16_W]) && (|a_i[MAN16_W-1:0]);
      nan_b     = (&b_i[FP16_W-2 -: EXP16_W]) && (|b_i[MAN16_W-1:0]);
      snan_a    = nan_a && !a_i[MAN16_W-1];
      snan_b    = nan_b && !b_i[MAN16_W-1];
      canon_nan = slice_word_t'(CANON_NAN16);
    end
  end

  assign zero_a = (mag_a == '0);
  assign zero_b = (mag_b == '0);

  // Sign-magnitude ordering of two non-NaN values
  always_comb begin : order
    if (zero_a && zero_b) begin
      // -0 sorts below +0
      a_lt_b = sign_a && !sign_b;
    end else if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  // ----------------------------------------
  // Operation
  // ----------------------------------------
  always_comb begin : compute
    result_o = a_i;
    status_o = '0;
    sign_inj = sign_b;
    case (op_i)
      OP_MIN, OP_MAX: begin
        status_o[NV_BIT] = snan_a || snan_b;
        if (nan_a && nan_b) begin
          result_o = canon_nan;
        end else if (nan_a) begin
          result_o = b_i;
        end else if (nan_b) begin
          result_o = a_i;
        end else if (op_i == OP_MIN) begin
          result_o = a_lt_b ? a_i : b_i;
        end else begin
          result_o = a_lt_b ? b_i : a_i;
        end
      end
      OP_SGNJ, OP_SGNJN, OP_SGNJX: begin
        if (op_i == OP_SGNJN) begin
          sign_inj = !sign_b;
        end else if (op_i == OP_SGNJX) begin
          sign_inj = sign_a ^ sign_b;
        end
        // Magnitude always from a, never raises flags
        if (fmt_i == FP32) begin
          result_o = {sign_inj, mag_a};
        end else begin
          result_o = slice_word_t'({sign_inj, mag_a[FP16_W-2:0]});
        end
      end
      default: begin
        result_o = a_i;
      end
    endcase
  end

endmodule

// ==== verilog/result_pack.sv ====
`timescale 1ns/1ps
/* Assembles the slice result from the lane outputs according to the result format.
   Unused upper bits are NaN-boxed and lane flags are merged into one status. */
module result_pack
  import fp_defs_pkg::*;
  import slice_ctrl_pkg::*;
(
  input  slice_word_t lane0_result_i,
  input  slice_word_t lane1_result_i,
  input  status_t     lane0_status_i,
  input  status_t     lane1_status_i,
  input  logic        lane1_valid_i,
  input  aux_t        aux_i,
  output slice_word_t result_o,
  output status_t     status_o,
  output logic        extension_bit_o
);

  // NaN-boxing value for bits no lane drives
  localparam logic EXT_BIT = 1'b1;

  fp_fmt_e    res_fmt;
  lane_word_t upper_half;

  assign res_fmt = fp_fmt_e'(aux_i[AUX_FMT_BIT]);

  // Lane 1 only fills the top half when it holds a live vector element
  assign upper_half = lane1_valid_i ? lane1_result_i[FP16_W-1:0] : {FP16_W{EXT_BIT}};

  // ----------------------------------------
  // Result by format
  // ----------------------------------------
  always_comb begin : pack
    if (res_fmt == FP32) begin
      result_o = lane0_result_i;
    end else begin
      result_o = {upper_half, lane0_result_i[FP16_W-1:0]};
    end
  end

  // Inactive lanes contribute no flags
  assign status_o = lane0_status_i | (lane1_valid_i ? lane1_status_i : '0);

  assign extension_bit_o = EXT_BIT;

endmodule

// ==== verilog/noncomp_multifmt_slice.sv ====
`timescale 1ns/1ps
/* Two-lane non-computational FP slice: FP32 scalar, FP16 scalar or FP16 two-lane vector.
   Lanes compute combinationally and share one valid/ready pipeline handshake. */
module noncomp_multifmt_slice
  import fp_defs_pkg::*;
  import slice_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  slice_word_t operands_a_i,
  input  slice_word_t operands_b_i,
  input  noncomp_op_e op_i,
  input  fp_fmt_e     fmt_i,
  input  logic        vectorial_op_i,
  input  tag_t        tag_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  logic        flush_i,
  output slice_word_t result_o,
  output status_t     status_o,
  output logic        extension_bit_o,
  output tag_t        tag_o,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output logic        busy_o
);

  localparam int unsigned LANE0_W =
      $bits(slice_word_t) + $bits(status_t) + $bits(tag_t) + $bits(aux_t);
  localparam int unsigned LANE1_W = $bits(lane_word_t) + $bits(status_t);

  logic                 is_vector;
  aux_t                 in_aux, out_aux;
  slice_word_t          lane0_a, lane0_b;
  lane_word_t           lane1_a, lane1_b;
  slice_word_t          lane0_result, lane1_result, out0_result;
  lane_word_t           out1_result;
  status_t              lane0_status, lane1_status, out0_status, out1_status;
  logic [LANE0_W-1:0]   lane0_pipe_in, lane0_pipe_out;
  logic [LANE1_W-1:0]   lane1_pipe_in, lane1_pipe_out;
  logic                 lane1_raw_valid;
  logic [NUM_LANES-1:0] lane_in_valid, lane_out_ready, lane_out_valid, lane_busy;

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  // FP32 has no second lane, so a vector request there runs as scalar
  assign is_vector = vectorial_op_i && (fmt_i == FP16);

  always_comb begin : aux_encode
    in_aux              = '0;
    in_aux[AUX_VEC_BIT] = is_vector;
    in_aux[AUX_FMT_BIT] = fmt_i;
  end

  assign lane0_a = (fmt_i == FP32) ? operands_a_i : slice_word_t'(operands_a_i[FP16_W-1:0]);
  assign lane0_b = (fmt_i == FP32) ? operands_b_i : slice_word_t'(operands_b_i[FP16_W-1:0]);
  assign lane1_a = operands_a_i[SLICE_W-1:FP16_W];
  assign lane1_b = operands_b_i[SLICE_W-1:FP16_W];

  assign lane_in_valid[0] = in_valid_i;
  assign lane_in_valid[1] = in_valid_i && is_vector;

  // ----------------------------------------
  // Lanes
  // ----------------------------------------
  noncomp_lane u_lane0 (
    .a_i      (lane0_a),
    .b_i      (lane0_b),
    .op_i     (op_i),
    .fmt_i    (fmt_i),
    .result_o (lane0_result),
    .status_o (lane0_status)
  );

  // Upper lane only ever sees FP16
  noncomp_lane u_lane1 (
    .a_i      (slice_word_t'(lane1_a)),
    .b_i      (slice_word_t'(lane1_b)),
    .op_i     (op_i),
    .fmt_i    (FP16),
    .result_o (lane1_result),
    .status_o (lane1_status)
  );

  assign lane0_pipe_in = {lane0_result, lane0_status, tag_i, in_aux};
  assign lane1_pipe_in = {lane1_result[FP16_W-1:0], lane1_status};

  lane_pipe #(.DATA_W(LANE0_W)) u_pipe0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (lane_in_valid[0]),
    .in_ready_o  (in_ready_o),
    .data_i      (lane0_pipe_in),
    .flush_i     (flush_i),
    .data_o      (lane0_pipe_out),
    .out_valid_o (lane_out_valid[0]),
    .out_ready_i (lane_out_ready[0]),
    .busy_o      (lane_busy[0])
  );

  // Lane 1 holds a subset of lane 0's items, so it has room whenever lane 0 does
  lane_pipe #(.DATA_W(LANE1_W)) u_pipe1 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (lane_in_valid[1]),
    .in_ready_o  (),
    .data_i      (lane1_pipe_in),
    .flush_i     (flush_i),
    .data_o      (lane1_pipe_out),
    .out_valid_o (lane1_raw_valid),
    .out_ready_i (lane_out_ready[1]),
    .busy_o      (lane_busy[1])
  );

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  assign {out0_result, out0_status, tag_o, out_aux} = lane0_pipe_out;
  assign {out1_result, out1_status}                 = lane1_pipe_out;

  // Lane 1 only handshakes while lane 0 presents a vector item
  assign lane_out_ready[0] = out_ready_i;
  assign lane_out_ready[1] = out_ready_i && out_aux[AUX_VEC_BIT];
  assign lane_out_valid[1] = lane1_raw_valid && out_aux[AUX_VEC_BIT];

  result_pack u_pack (
    .lane0_result_i  (out0_result),
    .lane1_result_i  (slice_word_t'(out1_result)),
    .lane0_status_i  (out0_status),
    .lane1_status_i  (out1_status),
    .lane1_valid_i   (lane_out_valid[1]),
    .aux_i           (out_aux),
    .result_o        (result_o),
    .status_o        (status_o),
    .extension_bit_o (extension_bit_o)
  );

  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = |lane_busy;

endmodule

// ==== tests/slice_asserts.sv ====
`timescale 1ns/1ps
/* Checker bound into the non-computational slice.
   Predicts every accepted operation and compares it with what the slice presents. */
module slice_asserts
  import fp_defs_pkg::*;
  import slice_ctrl_pkg::*;
(
  input logic        clk_i,
  input logic        rst_n_i,
  input slice_word_t operands_a_i,
  input slice_word_t operands_b_i,
  input noncomp_op_e op_i,
  input fp_fmt_e     fmt_i,
  input logic        vectorial_op_i,
  input tag_t        tag_i,
  input logic        in_valid_i,
  input logic        in_ready_o,
  input logic        flush_i,
  input slice_word_t result_o,
  input status_t     status_o,
  input logic        extension_bit_o,
  input tag_t        tag_o,
  input logic        out_valid_o,
  input logic        out_ready_i,
  input logic        busy_o
);

  localparam int unsigned DEPTH = 8;

  int          fail_count = 0;
  slice_word_t exp_res_mem [DEPTH];
  status_t     exp_st_mem  [DEPTH];
  tag_t        exp_tag_mem [DEPTH];
  logic [2:0]  wr_ptr, rd_ptr;
  logic [3:0]  count;
  logic        accept, retire;
  logic [32:0] ref_lo, ref_hi;
  slice_word_t exp_word, head_res;
  status_t     exp_status, head_st;
  tag_t        head_tag;

  // Returns {invalid flag, value} for one element with the value in the low bits
  function automatic logic [32:0] element_ref(input slice_word_t a, input slice_word_t b,
                                              input noncomp_op_e op, input logic half);
    slice_word_t sgn, expo, man, qbit, canon, mag_max, key_a, key_b, res;
    logic        nan_a, nan_b, nv, new_sign;
    sgn     = half ? 32'h0000_8000 : 32'h8000_0000;
    expo    = half ? 32'h0000_7c00 : 32'h7f80_0000;
    man     = half ? 32'h0000_03ff : 32'h007f_ffff;
    qbit    = half ? 32'h0000_0200 : 32'h0040_0000;
    canon   = half ? 32'h0000_7e00 : 32'h7fc0_0000;
    mag_max = expo | man;
    a       = a & (sgn | mag_max);
    b       = b & (sgn | mag_max);
    nan_a   = ((a & expo) == expo) && ((a & man) != 0);
    nan_b   = ((b & expo) == expo) && ((b & man) != 0);
    nv      = (nan_a && ((a & qbit) == 0)) || (nan_b && ((b & qbit) == 0));
    // Ordering key puts negatives below -0 and -0 below +0
    key_a   = ((a & sgn) != 0) ? mag_max - (a & mag_max) : mag_max + 1 + (a & mag_max);
    key_b   = ((b & sgn) != 0) ? mag_max - (b & mag_max) : mag_max + 1 + (b & mag_max);
    if (op == OP_MIN || op == OP_MAX) begin
      if (nan_a && nan_b) begin
        res = canon;
      end else if (nan_a) begin
        res = b;
      end else if (nan_b) begin
        res = a;
      end else if (op == OP_MIN) begin
        res = (key_b < key_a) ? b : a;
      end else begin
        res = (key_b > key_a) ? b : a;
      end
    end else begin
      case (op)
        OP_SGNJ:  new_sign = (b & sgn) != 0;
        OP_SGNJN: new_sign = (b & sgn) == 0;
        default:  new_sign = ((a ^ b) & sgn) != 0;
      endcase
      res = (a & mag_max) | (new_sign ? sgn : '0);
      nv  = 1'b0;
    end
    return {nv, res};
  endfunction

  assign accept = in_valid_i && in_ready_o && !flush_i;
  assign retire = out_valid_o && out_ready_i;

  // ----------------------------------------
  // Expected value of the offered operation
  // ----------------------------------------
  always_comb begin : predict
    ref_lo     = element_ref(operands_a_i, operands_b_i, op_i, fmt_i == FP16);
    ref_hi     = element_ref(operands_a_i >> FP16_W, operands_b_i >> FP16_W, op_i, 1'b1);
    exp_status = '0;
    if (fmt_i == FP32) begin
      exp_word           = ref_lo[31:0];
      exp_status[NV_BIT] = ref_lo[32];
    end else if (vectorial_op_i) begin
      exp_word           = {ref_hi[15:0], ref_lo[15:0]};
      exp_status[NV_BIT] = ref_lo[32] | ref_hi[32];
    end else begin
      // Scalar FP16 comes back NaN-boxed
      exp_word           = {16'hffff, ref_lo[15:0]};
      exp_status[NV_BIT] = ref_lo[32];
    end
  end

  // In-order queue of predictions that a flush empties
  always_ff @(posedge clk_i) begin : track
    if (!rst_n_i || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (accept) begin
        exp_res_mem[wr_ptr] <= exp_word;
        exp_st_mem[wr_ptr]  <= exp_status;
        exp_tag_mem[wr_ptr] <= tag_i;
        wr_ptr              <= wr_ptr + 1'b1;
      end
      if (retire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + 4'(accept) - 4'(retire);
    end
  end

  assign head_res = exp_res_mem[rd_ptr];
  assign head_st  = exp_st_mem[rd_ptr];
  assign head_tag = exp_tag_mem[rd_ptr];

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_reset_idle: assert property (@(posedge clk_i)
      !rst_n_i |=> !out_valid_o && !busy_o && in_ready_o)
    else begin
      fail_count++;
      $error("Slice was not idle and ready after a reset cycle at %0t", $time);
    end

  a_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o |-> count != 0)
    else begin
      fail_count++;
      $error("Output presented at %0t with no accepted operation pending", $time);
    end

  // An accepted operation stays in flight until it retires or is flushed
  a_drained: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      busy_o == (count != 0))
    else begin
      fail_count++;
      $error("MISMATCH at %0t: busy_o got %b expected %b",
             $time, $sampled(busy_o), $sampled(count) != 0);
    end

  a_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && count != 0 |-> result_o == head_res)
    else begin
      fail_count++;
      $error("MISMATCH at %0t: result_o got %h expected %h",
             $time, $sampled(result_o), $sampled(head_res));
    end

  a_status: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && count != 0 |-> status_o == head_st)
    else begin
      fail_count++;
      $error("MISMATCH at %0t: status_o got %b expected %b",
             $time, $sampled(status_o), $sampled(head_st));
    end

  a_tag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && count != 0 |-> tag_o == head_tag)
    else begin
      fail_count++;
      $error("MISMATCH at %0t: tag_o got %h expected %h",
             $time, $sampled(tag_o), $sampled(head_tag));
    end

  a_ext_bit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o |-> extension_bit_o)
    else begin
      fail_count++;
      $error("MISMATCH at %0t: extension_bit_o got %b expected 1",
             $time, $sampled(extension_bit_o));
    end

  // Two register stages between acceptance and output
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (accept && out_ready_i) ##1 (out_ready_i && !flush_i) |=> out_valid_o)
    else begin
      fail_count++;
      $error("Accepted operation did not reach the output two cycles later at %0t", $time);
    end

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o))
    else begin
      fail_count++;
      $error("Stalled output item changed or vanished at %0t", $time);
    end

  a_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      flush_i |=> !out_valid_o && !busy_o)
    else begin
      fail_count++;
      $error("Flush did not empty the slice by the next cycle at %0t", $time);
    end

endmodule

// ==== tests/slice_tb.sv ====
`timescale 1ns/1ps
/* Testbench for the non-computational slice, checking is done by the bound checker.
   Runs the test sequence with a watchdog and prints the summary. */
module slice_tb
  import fp_defs_pkg::*;
  import slice_ctrl_pkg::*;
();

  localparam int unsigned CLK_NS       = 8;
  localparam int unsigned NUM_TESTS    = 6;
  localparam int unsigned OPS_PER_TEST = 40;
  localparam int unsigned STALL_CYCLES = 4;
  // Margin of 4 over the worst expected run length
  localparam int unsigned WATCHDOG_NS  =
      4 * NUM_TESTS * OPS_PER_TEST * (NUM_PIPE_REGS + STALL_CYCLES) * CLK_NS;

  localparam int READY_HIGH   = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_LOW    = 2;

  logic        clk_i, rst_n_i;
  slice_word_t operands_a_i, operands_b_i, result_o;
  noncomp_op_e op_i;
  fp_fmt_e     fmt_i;
  logic        vectorial_op_i, in_valid_i, in_ready_o, flush_i;
  logic        extension_bit_o, out_valid_o, out_ready_i, busy_o;
  tag_t        tag_i, tag_o, tag_cnt;
  status_t     status_o;

  int seed = 32'hb911ef37;
  int ready_mode;
  int fail_base;
  int tests_run;
  int ops_sent;
  int total_fail;

  noncomp_multifmt_slice UUT (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .operands_a_i    (operands_a_i),
    .operands_b_i    (operands_b_i),
    .op_i            (op_i),
    .fmt_i           (fmt_i),
    .vectorial_op_i  (vectorial_op_i),
    .tag_i           (tag_i),
    .in_valid_i      (in_valid_i),
    .in_ready_o      (in_ready_o),
    .flush_i         (flush_i),
    .result_o        (result_o),
    .status_o        (status_o),
    .extension_bit_o (extension_bit_o),
    .tag_o           (tag_o),
    .out_valid_o     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .busy_o          (busy_o)
  );

  bind noncomp_multifmt_slice slice_asserts u_asserts (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  // Output ready follows the selected mode
  always @(posedge clk_i) begin
    case (ready_mode)
      READY_RANDOM: out_ready_i <= $random(seed);
      READY_LOW:    out_ready_i <= 1'b0;
      default:      out_ready_i <= 1'b1;
    endcase
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  // Offer one operation and hold it until the slice takes it
  task automatic drive_op(input slice_word_t a, input slice_word_t b, input noncomp_op_e op,
                          input fp_fmt_e fmt, input logic vec);
    logic taken;
    operands_a_i   <= a;
    operands_b_i   <= b;
    op_i           <= op;
    fmt_i          <= fmt;
    vectorial_op_i <= vec;
    tag_i          <= tag_cnt;
    in_valid_i     <= 1'b1;
    tag_cnt        = tag_cnt + 1'b1;
    taken          = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = in_ready_o;
      @(posedge clk_i);
    end
    in_valid_i <= 1'b0;
    ops_sent++;
  endtask

  // Random value with a bias towards zeros and NaNs
  task automatic pick_value(input logic half, output slice_word_t v);
    int unsigned pick;
    pick = $unsigned($random(seed)) % 8;
    case (pick)
      0: v = '0;
      1: v = half ? 32'h0000_8000 : 32'h8000_0000;
      2: v = half ? 32'h0000_7e01 : 32'h7fc0_0001;
      3: v = half ? 32'h0000_7d00 : 32'h7fa0_0000;
      default: v = $random(seed);
    endcase
    if (half) begin
      v = v & 32'h0000_ffff;
    end
  endtask

  task automatic pick_word(input fp_fmt_e fmt, output slice_word_t w);
    slice_word_t lo, hi;
    pick_value(fmt == FP16, lo);
    pick_value(fmt == FP16, hi);
    w = (fmt == FP16) ? {hi[15:0], lo[15:0]} : lo;
  endtask

  task automatic run_random(input int n, input fp_fmt_e fmt, input logic vec,
                            input int op_lo, input int op_hi);
    slice_word_t a, b;
    noncomp_op_e op;
    for (int i = 0; i < n; i++) begin
      pick_word(fmt, a);
      pick_word(fmt, b);
      op = noncomp_op_e'(op_lo + $unsigned($random(seed)) % (op_hi - op_lo + 1));
      drive_op(a, b, op, fmt, vec);
    end
  endtask

  task automatic wait_idle();
    @(negedge clk_i);
    while (busy_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  task automatic begin_test();
    fail_base = UUT.u_asserts.fail_count;
  endtask

  task automatic end_test(input string name);
    int delta;
    delta = UUT.u_asserts.fail_count - fail_base;
    tests_run++;
    $display("[%0t] %s: %0d failure(s)", $time, name, delta);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : main
    rst_n_i        = 1'b0;
    operands_a_i   = '0;
    operands_b_i   = '0;
    op_i           = OP_MIN;
    fmt_i          = FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b1;
    ready_mode     = READY_HIGH;
    tag_cnt        = '0;
    tests_run      = 0;
    ops_sent       = 0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;

    begin_test();
    repeat (4) @(posedge clk_i);
    end_test("reset_idle");

    // -0 against +0, sNaN against a number, qNaN against sNaN
    begin_test();
    drive_op(32'h8000_0000, 32'h0000_0000, OP_MIN, FP32, 1'b0);
    drive_op(32'h0000_0000, 32'h8000_0000, OP_MAX, FP32, 1'b0);
    drive_op(32'h7fa0_0000, 32'h3f80_0000, OP_MAX, FP32, 1'b0);
    drive_op(32'h7fc0_0000, 32'hffa0_0000, OP_MIN, FP32, 1'b0);
    run_random(OPS_PER_TEST, FP32, 1'b0, OP_MIN, OP_MAX);
    wait_idle();
    end_test("fp32_minmax");

    // sNaN only in the upper half still raises NV
    begin_test();
    drive_op(32'h7d00_3c00, 32'h4000_4000, OP_MIN, FP16, 1'b1);
    run_random(OPS_PER_TEST, FP16, 1'b1, OP_MIN, OP_SGNJX);
    wait_idle();
    end_test("fp16_vector");

    begin_test();
    run_random(OPS_PER_TEST, FP16, 1'b0, OP_MIN, OP_SGNJX);
    run_random(OPS_PER_TEST / 2, FP32, 1'b0, OP_SGNJ, OP_SGNJX);
    wait_idle();
    end_test("fp16_scalar_sgnj");

    begin_test();
    ready_mode <= READY_RANDOM;
    run_random(OPS_PER_TEST, FP16, 1'b1, OP_MIN, OP_SGNJX);
    run_random(OPS_PER_TEST / 2, FP32, 1'b0, OP_MIN, OP_SGNJX);
    wait_idle();
    ready_mode <= READY_HIGH;
    end_test("back_pressure");

    // Fill both stages behind a stalled output, then drop them
    begin_test();
    ready_mode <= READY_LOW;
    run_random(2, FP32, 1'b0, OP_MIN, OP_MAX);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i    <= 1'b0;
    ready_mode <= READY_HIGH;
    @(posedge clk_i);
    run_random(8, FP16, 1'b1, OP_MIN, OP_SGNJX);
    wait_idle();
    end_test("flush");

    total_fail = UUT.u_asserts.fail_count;
    $display("Tests run: %0d, operations: %0d, failures: %0d", tests_run, ops_sent, total_fail);
    if (total_fail == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS * 1ns);
    $display("Run timed out after %0d ns before the test sequence finished", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== files.f ====
verilog/fp_defs_pkg.sv
verilog/slice_ctrl_pkg.sv
verilog/lane_pipe.sv
verilog/noncomp_lane.sv
verilog/result_pack.sv
verilog/noncomp_multifmt_slice.sv
tests/slice_asserts.sv
tests/slice_tb.sv
